// ==== cf_math_pkg.sv ====
/*
 * Math helper package
 * Small constant functions used to size index and count buses
 */

`default_nettype none

package cf_math_pkg;

  // Number of bits needed to address num_idx entries
  // A single entry still gets one bit so that buses never collapse to zero width
  function automatic int unsigned idx_width(input int unsigned num_idx);
    if (num_idx > 32'd1) begin
      return $clog2(num_idx);
    end else begin
      return 32'd1;
    end
  endfunction

endpackage : cf_math_pkg

`default_nettype wire

// ==== i2f_pkg.sv ====
/*
 * Integer to float converter package
 * Number format, request bus and control types of the converter
 */

`default_nettype none

package i2f_pkg;

  // Width of the integer operand, fixed by the single precision format
  localparam int unsigned INT_WIDTH = 32;

  // Exponent bias of IEEE-754 single precision
  localparam int unsigned EXP_BIAS = 127;

  // Interpretation of the operand
  typedef enum logic [0:0] {
    OP_UNSIGNED = 1'b0,
    OP_SIGNED   = 1'b1
  } conv_op_e;

  // Conversion request, opcode in the top bit
  typedef struct packed {
    conv_op_e               op;
    logic [INT_WIDTH-1:0]   operand;
  } conv_req_t;

  // Single precision float as it appears on the result bus
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  // States of the sequencing FSM
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_COUNT = 2'd1,
    ST_SHIFT = 2'd2,
    ST_ROUND = 2'd3
  } ctrl_state_e;

endpackage : i2f_pkg

`default_nettype wire

// ==== lzc.sv ====
/*
 * Leading / trailing zero counter
 * Finds the first set bit through a binary tree of select and index nodes
 */

`timescale 1ns/1ps
`default_nettype none

module lzc #(
  // Width of the vector to scan
  parameter int unsigned WIDTH     = 2,
  // 0 counts trailing zeros, 1 counts leading zeros
  parameter bit          MODE      = 1'b0,
  // Width of the count, derived from WIDTH
  parameter int unsigned CNT_WIDTH = cf_math_pkg::idx_width(WIDTH)
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  if (WIDTH <= 1) begin : gen_single_bit

    // One bit has either zero or one zero in front of it
    assign cnt_o[0] = ~in_i[0];
    assign empty_o  = ~in_i[0];

  end else begin : gen_tree

    localparam int unsigned Levels = $clog2(WIDTH);

    // Scan vector, always searched from bit 0 upwards
    logic [WIDTH-1:0]                    scan_vec;
    // Position of every input bit, used as the leaf value of the tree
    logic [WIDTH-1:0][Levels-1:0]        leaf_idx;
    // Node holds a set bit somewhere in its subtree
    logic [2**Levels-2:0]                node_sel;
    // Lowest set position found in the node's subtree
    logic [2**Levels-2:0][Levels-1:0]    node_idx;

    if (MODE) begin : gen_reverse
      // For a leading zero count the MSB becomes position 0
      always_comb begin
        for (int unsigned i = 0; i < WIDTH; i++) begin
          scan_vec[i] = in_i[WIDTH-1-i];
        end
      end
    end else begin : gen_straight
      assign scan_vec = in_i;
    end

    for (genvar j = 0; j < WIDTH; j++) begin : gen_leaf_idx
      assign leaf_idx[j] = Levels'(j);
    end

    // Node n of level lv sits at flat position 2**lv - 1 + n, root at 0
    for (genvar lv = 0; lv < Levels; lv++) begin : gen_level
      if (lv == Levels - 1) begin : gen_leaves
        for (genvar n = 0; n < 2 ** lv; n++) begin : gen_node
          if (n * 2 < WIDTH - 1) begin : gen_pair
            // Both input bits exist, the lower one wins
            assign node_sel[2**lv-1+n] = scan_vec[n*2] | scan_vec[n*2+1];
            assign node_idx[2**lv-1+n] = scan_vec[n*2] ? leaf_idx[n*2] : leaf_idx[n*2+1];
          end else if (n * 2 == WIDTH - 1) begin : gen_single
            // Odd width leaves a lone bit at the top
            assign node_sel[2**lv-1+n] = scan_vec[n*2];
            assign node_idx[2**lv-1+n] = leaf_idx[n*2];
          end else begin : gen_unused
            // Padding nodes beyond the input never select
            assign node_sel[2**lv-1+n] = 1'b0;
            assign node_idx[2**lv-1+n] = '0;
          end
        end
      end else begin : gen_inner
        for (genvar n = 0; n < 2 ** lv; n++) begin : gen_node
          // Prefer the lower child whenever it has a set bit
          assign node_sel[2**lv-1+n] = node_sel[2**(lv+1)-1+n*2] |
                                       node_sel[2**(lv+1)-1+n*2+1];
          assign node_idx[2**lv-1+n] = node_sel[2**(lv+1)-1+n*2] ?
                                       node_idx[2**(lv+1)-1+n*2] :
                                       node_idx[2**(lv+1)-1+n*2+1];
        end
      end
    end

    // With no set bit every node picks its upper child, giving WIDTH-1
    assign cnt_o   = CNT_WIDTH'(node_idx[0]);
    assign empty_o = ~node_sel[0];

  end

endmodule : lzc

`default_nettype wire

// ==== i2f_ctrl.sv ====
/*
 * Converter control FSM
 * Sequences load, count, step-wise shift and round of one conversion
 */

`timescale 1ns/1ps
`default_nettype none

module i2f_ctrl (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic shift_zero_i,
  output logic load_o,
  output logic count_en_o,
  output logic shift_en_o,
  output logic round_en_o,
  output logic busy_o,
  output logic done_o
);

  i2f_pkg::ctrl_state_e state_q;
  i2f_pkg::ctrl_state_e state_d;
  logic                 done_q;

  // Next state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      i2f_pkg::ST_IDLE: begin
        // Starts are only taken here, so a strobe while busy is dropped
        if (start_i) begin
          state_d = i2f_pkg::ST_COUNT;
        end
      end
      i2f_pkg::ST_COUNT: begin
        state_d = i2f_pkg::ST_SHIFT;
      end
      i2f_pkg::ST_SHIFT: begin
        // Stay until the remaining shift distance has run out
        if (shift_zero_i) begin
          state_d = i2f_pkg::ST_ROUND;
        end
      end
      i2f_pkg::ST_ROUND: begin
        state_d = i2f_pkg::ST_IDLE;
      end
      default: begin
        state_d = i2f_pkg::ST_IDLE;
      end
    endcase
  end

  // Step enables decoded from the current state
  assign load_o     = (state_q == i2f_pkg::ST_IDLE) & start_i;
  assign count_en_o = (state_q == i2f_pkg::ST_COUNT);
  // No shift on the cycle that only detects the end of shifting
  assign shift_en_o = (state_q == i2f_pkg::ST_SHIFT) & ~shift_zero_i;
  assign round_en_o = (state_q == i2f_pkg::ST_ROUND);

  // Busy covers every state past acceptance up to the done edge
  assign busy_o = (state_q != i2f_pkg::ST_IDLE);
  assign done_o = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= i2f_pkg::ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // One-cycle pulse, same edge on which the result is registered
      done_q  <= round_en_o;
    end
  end

endmodule : i2f_ctrl

`default_nettype wire

// ==== shift_counter.sv ====
/*
 * Normalization shift counter
 * Tracks the remaining left shift and hands out at most STEP bits per cycle
 */

`timescale 1ns/1ps
`default_nettype none

module shift_counter #(
  // Largest shift applied in a single cycle
  parameter int unsigned STEP = 8
) (
  input  logic                                                      clk_i,
  input  logic                                                      arst_n_i,
  input  logic                                                      count_en_i,
  input  logic [cf_math_pkg::idx_width(i2f_pkg::INT_WIDTH)-1:0]     lz_i,
  input  logic                                                      shift_en_i,
  output logic [cf_math_pkg::idx_width(i2f_pkg::INT_WIDTH)-1:0]     step_o,
  output logic                                                      shift_zero_o
);

  localparam int unsigned CNT_WIDTH = cf_math_pkg::idx_width(i2f_pkg::INT_WIDTH);

  // Shift distance still to be applied to the magnitude
  logic [CNT_WIDTH-1:0] remain_q;

  // The remaining distance never exceeds INT_WIDTH-1, so a STEP of
  // INT_WIDTH or more always takes the first branch
  assign step_o = (int'(remain_q) < int'(STEP)) ? remain_q : CNT_WIDTH'(STEP);

  assign shift_zero_o = (remain_q == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      remain_q <= '0;
    end else if (count_en_i) begin
      // Full distance is the leading zero count of the loaded magnitude
      remain_q <= lz_i;
    end else if (shift_en_i) begin
      remain_q <= remain_q - step_o;
    end
  end

endmodule : shift_counter

`default_nettype wire

// ==== norm_shifter.sv ====
/*
 * Normalization shifter
 * Holds the operand magnitude and shifts it left by the step amount
 */

`timescale 1ns/1ps
`default_nettype none

module norm_shifter (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  logic                                                  load_i,
  input  i2f_pkg::conv_req_t                                    req_i,
  input  logic                                                  shift_en_i,
  input  logic [cf_math_pkg::idx_width(i2f_pkg::INT_WIDTH)-1:0] step_i,
  output logic [i2f_pkg::INT_WIDTH-1:0]                         mag_o
);

  logic [i2f_pkg::INT_WIDTH-1:0] mag_q;
  logic [i2f_pkg::INT_WIDTH-1:0] abs_val;
  logic                          negative;

  // Only a signed operand with its top bit set is negative
  assign negative = (req_i.op == i2f_pkg::OP_SIGNED) & req_i.operand[i2f_pkg::INT_WIDTH-1];

  // Two's complement negate; -2^31 maps onto 0x8000_0000 read as unsigned
  assign abs_val = negative ? (~req_i.operand + 1'b1) : req_i.operand;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mag_q <= '0;
    end else if (load_i) begin
      mag_q <= abs_val;
    end else if (shift_en_i) begin
      // Bits moved out at the top are always zero, the count guarantees it
      mag_q <= mag_q << step_i;
    end
  end

  // Feeds the zero counter before shifting and the rounder afterwards
  assign mag_o = mag_q;

endmodule : norm_shifter

`default_nettype wire

// ==== round_pack.sv ====
/*
 * Round and pack stage
 * Keeps sign and exponent, rounds the normalized magnitude to nearest-even
 */

`timescale 1ns/1ps
`default_nettype none

module round_pack (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  logic                                                  load_i,
  input  i2f_pkg::conv_req_t                                    req_i,
  input  logic                                                  count_en_i,
  input  logic [cf_math_pkg::idx_width(i2f_pkg::INT_WIDTH)-1:0] lz_i,
  input  logic                                                  empty_i,
  input  logic                                                  round_en_i,
  input  logic [i2f_pkg::INT_WIDTH-1:0]                         mag_i,
  output i2f_pkg::fp32_t                                        result_o
);

  // Lowest magnitude bit that still lands in the 23-bit mantissa
  localparam int unsigned MAN_LSB = i2f_pkg::INT_WIDTH - 24;

  logic           sign_q;
  logic [7:0]     exp_q;
  logic           zero_q;
  i2f_pkg::fp32_t result_q;

  logic [22:0]    mant;
  logic           guard;
  logic           sticky;
  logic           round_up;
  logic [23:0]    mant_rnd;
  logic [7:0]     exp_rnd;

  // Hidden bit sits at the MSB after normalization and is dropped
  assign mant   = mag_i[i2f_pkg::INT_WIDTH-2:MAN_LSB];
  assign guard  = mag_i[MAN_LSB-1];
  assign sticky = |mag_i[MAN_LSB-2:0];

  // Ties go to the even mantissa, anything above half rounds up
  assign round_up = guard & (sticky | mant[0]);

  // Extra bit catches the carry out of an all-ones mantissa
  assign mant_rnd = {1'b0, mant} + 24'(round_up);
  assign exp_rnd  = exp_q + 8'(mant_rnd[23]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sign_q   <= 1'b0;
      exp_q    <= '0;
      zero_q   <= 1'b0;
      result_q <= '0;
    end else begin
      if (load_i) begin
        sign_q <= (req_i.op == i2f_pkg::OP_SIGNED) & req_i.operand[i2f_pkg::INT_WIDTH-1];
      end
      if (count_en_i) begin
        // Value is 1.f times 2 to the power of the MSB position
        exp_q  <= 8'(i2f_pkg::EXP_BIAS + i2f_pkg::INT_WIDTH - 1 - int'(lz_i));
        zero_q <= empty_i;
      end
      if (round_en_i) begin
        if (zero_q) begin
          // Zero has no leading one and is always positive
          result_q <= '0;
        end else begin
          result_q.sign     <= sign_q;
          result_q.exponent <= exp_rnd;
          result_q.mantissa <= mant_rnd[22:0];
        end
      end
    end
  end

  // Held until the next conversion rounds
  assign result_o = result_q;

endmodule : round_pack

`default_nettype wire

// ==== i2f_top.sv ====
/*
 * Integer to single precision float converter
 * Multi-cycle unit with a start strobe, busy level and done pulse
 */

`timescale 1ns/1ps
`default_nettype none

module i2f_top #(
  // Largest normalization shift per cycle, 1 up to INT_WIDTH
  parameter int unsigned STEP = 8
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               start_i,
  input  i2f_pkg::conv_req_t req_i,
  output logic               busy_o,
  output logic               done_o,
  output i2f_pkg::fp32_t     result_o
);

  localparam int unsigned CNT_WIDTH = cf_math_pkg::idx_width(i2f_pkg::INT_WIDTH);

  // Step enables from the FSM
  logic                          load;
  logic                          count_en;
  logic                          shift_en;
  logic                          round_en;
  logic                          shift_zero;

  // Datapath between the stages
  logic [i2f_pkg::INT_WIDTH-1:0] mag;
  logic [CNT_WIDTH-1:0]          lz;
  logic                          lz_empty;
  logic [CNT_WIDTH-1:0]          step;

  i2f_ctrl u_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start_i),
    .shift_zero_i (shift_zero),
    .load_o       (load),
    .count_en_o   (count_en),
    .shift_en_o   (shift_en),
    .round_en_o   (round_en),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  shift_counter #(
    .STEP (STEP)
  ) u_shift_counter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .count_en_i   (count_en),
    .lz_i         (lz),
    .shift_en_i   (shift_en),
    .step_o       (step),
    .shift_zero_o (shift_zero)
  );

  norm_shifter u_norm_shifter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .load_i     (load),
    .req_i      (req_i),
    .shift_en_i (shift_en),
    .step_i     (step),
    .mag_o      (mag)
  );

  // Leading zero count of the magnitude as loaded
  lzc #(
    .WIDTH     (i2f_pkg::INT_WIDTH),
    .MODE      (1'b1),
    .CNT_WIDTH (CNT_WIDTH)
  ) u_lzc (
    .in_i    (mag),
    .cnt_o   (lz),
    .empty_o (lz_empty)
  );

  round_pack u_round_pack (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .load_i     (load),
    .req_i      (req_i),
    .count_en_i (count_en),
    .lz_i       (lz),
    .empty_i    (lz_empty),
    .round_en_i (round_en),
    .mag_i      (mag),
    .result_o   (result_o)
  );

endmodule : i2f_top

`default_nettype wire

// ==== tb_i2f_top.sv ====
/*
 * Testbench of the integer to float converter
 * Replays vectors from i2f_testdata.txt and checks the start, busy and done handshake
 */

`timescale 1ns/1ps
`default_nettype none

module tb_i2f_top;

  localparam int unsigned STEP       = 8;
  localparam int unsigned MAX_VEC    = 64;
  localparam int unsigned TIMEOUT    = 40;
  localparam int unsigned NUM_RANDOM = 16;

  logic               clk;
  logic               arst_n;
  logic               start;
  i2f_pkg::conv_req_t req;
  logic               busy;
  logic               done;
  i2f_pkg::fp32_t     result;

  // One vector per entry: opcode digit, operand, expected float
  logic [67:0] vec_mem [0:MAX_VEC-1];
  int unsigned error_count;
  int unsigned test_count;
  integer      seed;

  i2f_top #(
    .STEP (STEP)
  ) UUT (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .start_i  (start),
    .req_i    (req),
    .busy_o   (busy),
    .done_o   (done),
    .result_o (result)
  );

  // 20 ns clock period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_result(input i2f_pkg::fp32_t got, input i2f_pkg::fp32_t expected,
                              input string what);
    if (got !== expected) begin
      $display("ERROR at %0t: %s gave %h (s %b e %h m %h), expected %h", $time, what, got,
               got.sign, got.exponent, got.mantissa, expected);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, expected);
      error_count++;
    end
  endtask

  // Start strobe is high for exactly one rising edge, the DUT accepts it there
  task automatic start_conversion(input i2f_pkg::conv_op_e op, input logic [31:0] operand);
    @(posedge clk);
    start       <= 1'b1;
    req.op      <= op;
    req.operand <= operand;
    @(posedge clk);
    start       <= 1'b0;
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change
  task automatic wait_done(output bit seen);
    i2f_pkg::ctrl_state_e state;
    seen = 1'b0;
    for (int unsigned cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
      @(negedge clk);
      if (done === 1'b1) begin
        seen = 1'b1;
        // Busy drops on the same edge that raises done
        check_flag(busy, 1'b0, "busy_o on the done cycle");
      end else begin
        check_flag(busy, 1'b1, "busy_o during conversion");
      end
    end
    if (!seen) begin
      state = UUT.u_ctrl.state_q;
      $display("Converter hung: no done pulse within %0d cycles, FSM stuck in %s",
               TIMEOUT, state.name());
      error_count++;
    end
  endtask

  // Done must be a single-cycle pulse
  task automatic check_pulse_end();
    @(negedge clk);
    check_flag(done, 1'b0, "done_o one cycle after the pulse");
  endtask

  task automatic run_vector(input int unsigned idx);
    i2f_pkg::conv_op_e op;
    logic [31:0]       operand;
    i2f_pkg::fp32_t    expected;
    int unsigned       errors_before;
    bit                seen;
    op            = i2f_pkg::conv_op_e'(vec_mem[idx][64]);
    operand       = vec_mem[idx][63:32];
    expected      = vec_mem[idx][31:0];
    errors_before = error_count;
    start_conversion(op, operand);
    wait_done(seen);
    // Result is valid together with the done pulse
    if (seen) begin
      check_result(result, expected, $sformatf("vector %0d", idx));
    end
    check_pulse_end();
    test_count++;
    $display("Vector %0d: %s %h -> %h, %s", idx, op.name(), operand, result,
             (error_count == errors_before) ? "ok" : "wrong");
  endtask

  initial begin
    int unsigned       num_vec;
    int unsigned       errors_before;
    int unsigned       extra_done;
    bit                seen;
    logic [31:0]       rnd_operand;
    logic [31:0]       rnd_word;
    i2f_pkg::conv_op_e rnd_op;

    error_count = 0;
    test_count  = 0;
    seed        = 32'hf68b5372;
    arst_n      = 1'b0;
    start       = 1'b0;
    req         = '0;
    $readmemh("i2f_testdata.txt", vec_mem);

    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    // Values right after reset
    errors_before = error_count;
    @(negedge clk);
    check_flag(busy, 1'b0, "busy_o after reset");
    check_flag(done, 1'b0, "done_o after reset");
    check_result(result, '0, "result_o after reset");
    test_count++;
    $display("Reset state: %s", (error_count == errors_before) ? "ok" : "wrong");

    // Entries the file did not fill stay unknown and end the list
    num_vec = 0;
    while (num_vec < MAX_VEC && (^vec_mem[num_vec] !== 1'bx)) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      $display("No test vectors could be read from i2f_testdata.txt");
      error_count++;
    end
    for (int unsigned i = 0; i < num_vec; i++) begin
      run_vector(i);
    end

    // A start while busy must be dropped and the first result must stay
    errors_before = error_count;
    start_conversion(i2f_pkg::OP_UNSIGNED, 32'h0000_0001);
    repeat (2) @(posedge clk);
    start       <= 1'b1;
    req.op      <= i2f_pkg::OP_UNSIGNED;
    req.operand <= 32'hFFFF_FFFF;
    @(posedge clk);
    start       <= 1'b0;
    wait_done(seen);
    if (seen) begin
      check_result(result, 32'h3F80_0000, "first request with a start while busy");
    end
    extra_done = 0;
    for (int unsigned cyc = 0; cyc < TIMEOUT; cyc++) begin
      @(negedge clk);
      if (done === 1'b1) begin
        extra_done++;
      end
      check_flag(busy, 1'b0, "busy_o after the ignored start");
      check_result(result, 32'h3F80_0000, "held result_o");
    end
    if (extra_done != 0) begin
      $display("ERROR at %0t: %0d extra done_o pulses after an ignored start", $time,
               extra_done);
      error_count++;
    end
    test_count++;
    $display("Ignored start and held result: %s",
             (error_count == errors_before) ? "ok" : "wrong");

    // Random operands only exercise the handshake
    for (int unsigned n = 0; n < NUM_RANDOM; n++) begin
      errors_before = error_count;
      rnd_operand   = $random(seed);
      rnd_word      = $random(seed);
      rnd_op        = i2f_pkg::conv_op_e'(rnd_word[0]);
      start_conversion(rnd_op, rnd_operand);
      wait_done(seen);
      if (seen) begin
        check_pulse_end();
      end
      test_count++;
      $display("Random %0d: %s %h handshake %s", n, rnd_op.name(), rnd_operand,
               (error_count == errors_before) ? "ok" : "wrong");
    end

    $display("Tests run %0d, errors %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_i2f_top

`default_nettype wire

// ==== i2f_testdata.txt ====
// Columns: opcode (0 unsigned, 1 signed) _ operand _ expected float, all hex
// Expected floats use round to nearest-even, zero packs as +0
0_00000001_3f800000
0_00000002_40000000
0_00000064_42c80000
0_80000000_4f000000
0_ffffffff_4f800000
0_7fffffff_4f000000
0_12345678_4d91a2b4
0_01000001_4b800000 // Tie, stays on the even mantissa
0_01000003_4b800002 // Tie, rounds up to the even mantissa
0_01000005_4b800002
0_02000003_4c000001 // Above the tie, rounds up
0_02000001_4c000000
0_ffffff80_4f800000 // Mantissa carry bumps the exponent
0_00000000_00000000
1_00000000_00000000
1_ffffffff_bf800000
1_80000000_cf000000
1_ffffff9c_c2c80000
1_fe000001_cc000000
1_00000005_40a00000

// ==== vlog.f ====
cf_math_pkg.sv
i2f_pkg.sv
lzc.sv
i2f_ctrl.sv
shift_counter.sv
norm_shifter.sv
round_pack.sv
i2f_top.sv
tb_i2f_top.sv

// ==== Bender.yml ====
package:
  name: i2f_converter

sources:
  # Packages first, the modules depend on them
  - cf_math_pkg.sv
  - i2f_pkg.sv
  # Converter RTL
  - lzc.sv
  - i2f_ctrl.sv
  - shift_counter.sv
  - norm_shifter.sv
  - round_pack.sv
  - i2f_top.sv
  # Testbench
  - target: simulation
    files:
      - tb_i2f_top.sv
